// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_wr_arbiter -f verilog.f -o sim_wr_arbiter

out=$(./obj_dir/sim_wr_arbiter) || true
echo "$out"

if echo "$out" | grep -q "Simulation finished: PASS"; then
    exit 0
else
    exit 1
fi

// File: tb_wr_arbiter.sv
module tb_wr_arbiter;

    timeunit 1ns;
    timeprecision 1ps;

    import wr_arb_pkg::*;

    logic ACLK;
    logic ARESETn;
    logic [NUM_MASTERS-1:0][ID_W-1:0]    m_awid;
    logic [NUM_MASTERS-1:0][ADDR_W-1:0]  m_awaddr;
    logic [NUM_MASTERS-1:0][LEN_W-1:0]   m_awlen;
    logic [NUM_MASTERS-1:0][SIZE_W-1:0]  m_awsize;
    logic [NUM_MASTERS-1:0][BURST_W-1:0] m_awburst;
    logic [NUM_MASTERS-1:0]              m_awvalid, m_awready;
    logic [NUM_MASTERS-1:0][DATA_W-1:0]  m_wdata;
    logic [NUM_MASTERS-1:0][STRB_W-1:0]  m_wstrb;
    logic [NUM_MASTERS-1:0]              m_wlast, m_wvalid, m_wready;
    logic [NUM_MASTERS-1:0][ID_W-1:0]    m_bid;
    logic [NUM_MASTERS-1:0][RESP_W-1:0]  m_bresp;
    logic [NUM_MASTERS-1:0]              m_bvalid, m_bready;
    logic [NUM_SLAVES-1:0]               s_awvalid, s_awready, s_wvalid, s_wready;
    logic [NUM_SLAVES-1:0][ID_W-1:0]     s_bid;
    logic [NUM_SLAVES-1:0][RESP_W-1:0]   s_bresp;
    logic [NUM_SLAVES-1:0]               s_bvalid, s_bready;
    logic [ID_W-1:0]    s_awid;
    logic [ADDR_W-1:0]  s_awaddr;
    logic [LEN_W-1:0]   s_awlen;
    logic [SIZE_W-1:0]  s_awsize;
    logic [BURST_W-1:0] s_awburst;
    logic [DATA_W-1:0]  s_wdata;
    logic [STRB_W-1:0]  s_wstrb;
    logic               s_wlast;

    // trace table, one row per transaction
    int          n_tr;
    int          tr_m[32], tr_len[32], tr_start[32], tr_bresp[32], tr_stall[32], tr_rank[32];
    logic [31:0] tr_addr[32];

    int          mst_st[NUM_MASTERS];           // 0 idle, 1 AW, 2 W, 3 B
    int          mst_ptr[NUM_MASTERS];          // current trace row, -1 when done
    int          mst_beat[NUM_MASTERS];
    logic [35:0] beat_q[$];                     // {strb, data} in send order
    integer      seed;
    int          cyc, limit, done_count;
    int          act_tx, act_m, act_slave, rcv_beat, aw_m, b_m;
    logic [ID_W-1:0] act_id;
    logic        aw_fire, w_fire, w_last_fire, b_fire;

    wr_arbiter_top dut_i (.*);

    initial begin
        ACLK = 1'b0;
        forever #4 ACLK = ~ACLK;
    end

    task automatic check_eq(input logic [63:0] got, input logic [63:0] exp, input string what);
        if (got !== exp) begin
            $display("[FAIL] %0t: %s got %0h expected %0h", $time, what, got, exp);
            $display("Simulation finished: FAIL");
            $fatal(1);
        end
    endtask

    function automatic int find_next_tx(input int m, input int from);
        for (int t = from + 1; t < n_tr; t++)
            if (tr_m[t] == m)
                return t;
        return -1;
    endfunction

    task automatic read_trace();
        int    fd;
        int    beats;
        string line;
        fd = $fopen("wr_trace.txt", "r");
        if (fd == 0) begin
            $display("ERROR: could not open the trace file wr_trace.txt");
            $display("Simulation finished: FAIL");
            $fatal(1);
        end
        n_tr  = 0;
        beats = 0;
        while ($fgets(line, fd) != 0) begin
            if (line.len() < 2 || line.substr(0, 0) == "#")
                continue;                       // header or blank
            if ($sscanf(line, "%d %h %d %d %d %d %d", tr_m[n_tr], tr_addr[n_tr],
                        tr_len[n_tr], tr_start[n_tr], tr_bresp[n_tr], tr_stall[n_tr],
                        tr_rank[n_tr]) == 7) begin
                beats += tr_len[n_tr] + 1;
                n_tr++;
            end
        end
        $fclose(fd);
        limit = 20 * beats + 200;
    endtask

    task automatic present_beat(input int m);
        logic [31:0] d;
        d            = $random(seed);
        m_wdata[m]   = d;
        m_wstrb[m]   = d[3:0];
        m_wlast[m]   = (mst_beat[m] == tr_len[mst_ptr[m]]);
        m_wvalid[m]  = 1'b1;
        beat_q.push_back({d[3:0], d});
    endtask

    // ----------------------------------------------------------------------
    // master and slave models, advanced on the falling edge
    // ----------------------------------------------------------------------
    task automatic update_models();
        logic stall;
        int   t;
        if (b_fire)
            s_bvalid = '0;
        if (w_last_fire) begin                  // answer right after WLAST
            s_bvalid[act_slave] = 1'b1;
            s_bid[act_slave]    = act_id;
            s_bresp[act_slave]  = RESP_W'(tr_bresp[act_tx]);
        end
        stall = 1'b0;
        for (int m = 0; m < NUM_MASTERS; m++)
            if (mst_st[m] != 0 && tr_stall[mst_ptr[m]] != 0)
                stall = 1'b1;
        for (int s = 0; s < NUM_SLAVES; s++) begin
            s_awready[s] = stall ? 1'($random(seed)) : 1'b1;
            s_wready[s]  = stall ? 1'($random(seed)) : 1'b1;
        end
        for (int m = 0; m < NUM_MASTERS; m++) begin
            t = mst_ptr[m];
            case (mst_st[m])
                0: if (t >= 0 && cyc >= tr_start[t]) begin
                    m_awid[m]    = ID_W'(8 + m);
                    m_awaddr[m]  = tr_addr[t];
                    m_awlen[m]   = LEN_W'(tr_len[t]);
                    m_awsize[m]  = 3'd2;        // 4 bytes per beat
                    m_awburst[m] = 2'd1;        // INCR
                    m_awvalid[m] = 1'b1;
                    mst_st[m]    = 1;
                end
                1: if (aw_fire && aw_m == m) begin
                    m_awvalid[m] = 1'b0;
                    mst_beat[m]  = 0;
                    mst_st[m]    = 2;
                    present_beat(m);
                end
                2: if (w_fire && act_m == m) begin
                    mst_beat[m]++;
                    if (mst_beat[m] > tr_len[t]) begin
                        m_wvalid[m] = 1'b0;
                        m_wlast[m]  = 1'b0;
                        m_bready[m] = 1'b1;
                        mst_st[m]   = 3;
                    end else begin
                        present_beat(m);
                    end
                end
                default: if (b_fire && b_m == m) begin
                    m_bready[m] = 1'b0;
                    mst_st[m]   = 0;
                    mst_ptr[m]  = find_next_tx(m, t);
                end
            endcase
        end
    endtask

    // ----------------------------------------------------------------------
    // sample settled handshakes, these transfer on the next rising edge
    // ----------------------------------------------------------------------
    task automatic sample_fires();
        logic [35:0] exp_beat;
        int          t;
        aw_fire     = 1'b0;
        w_fire      = 1'b0;
        w_last_fire = 1'b0;
        b_fire      = 1'b0;
        check_eq(64'($countones(m_awready) <= 1), 64'(1), "awready seen by a non-owner");
        if (act_tx >= 0)
            check_eq(64'(m_bvalid & ~(4'(1) << act_m)), 64'(0), "bvalid at a non-owner");
        else
            check_eq(64'(m_bvalid), 64'(0), "bvalid with no transaction");
        for (int m = 0; m < NUM_MASTERS; m++) begin
            if (m_awvalid[m] && m_awready[m]) begin
                t = mst_ptr[m];
                aw_fire   = 1'b1;
                aw_m      = m;
                act_tx    = t;
                act_m     = m;
                act_slave = int'(tr_addr[t][31:29]);
                rcv_beat  = 0;
                check_eq(64'(s_awvalid), 64'(8'(1) << act_slave), "s_awvalid routing");
                check_eq(64'(s_awaddr), 64'(tr_addr[t]), "s_awaddr");
                check_eq(64'(s_awid), 64'(8 + m), "s_awid");
                check_eq(64'(s_awlen), 64'(tr_len[t]), "s_awlen");
                check_eq(64'(s_awsize), 64'(2), "s_awsize");
                check_eq(64'(s_awburst), 64'(1), "s_awburst");
                act_id = s_awid;                // slave keeps the id it received
            end
        end
        if (act_tx >= 0 && s_wvalid[act_slave] && s_wready[act_slave]) begin
            w_fire = 1'b1;
            check_eq(64'(s_wvalid), 64'(8'(1) << act_slave), "s_wvalid routing");
            check_eq(64'(m_wready), 64'(4'(1) << act_m), "m_wready");
            check_eq(64'(beat_q.size() > 0), 64'(1), "data beat with none sent");
            exp_beat = beat_q.pop_front();
            check_eq(64'(s_wdata), 64'(exp_beat[31:0]), "s_wdata");
            check_eq(64'(s_wstrb), 64'(exp_beat[35:32]), "s_wstrb");
            check_eq(64'(s_wlast), 64'(rcv_beat == tr_len[act_tx]), "s_wlast");
            w_last_fire = s_wlast;
            rcv_beat++;
        end
        for (int m = 0; m < NUM_MASTERS; m++) begin
            if (m_bvalid[m] && m_bready[m]) begin
                b_fire = 1'b1;
                b_m    = m;
                check_eq(64'(m), 64'(act_m), "B at the wrong master");
                check_eq(64'(s_bready), 64'(8'(1) << act_slave), "s_bready routing");
                check_eq(64'(m_bid[m]), 64'(act_id), "m_bid");
                check_eq(64'(m_bresp[m]), 64'(tr_bresp[act_tx]), "m_bresp");
                check_eq(64'(done_count), 64'(tr_rank[act_tx]), "round-robin order");
                done_count++;
                act_tx = -1;
            end
        end
    endtask

    initial begin
        seed      = 72;
        ARESETn   = 1'b0;
        m_awid    = '0;
        m_awaddr  = '0;
        m_awlen   = '0;
        m_awsize  = '0;
        m_awburst = '0;
        m_awvalid = '0;
        m_wdata   = '0;
        m_wstrb   = '0;
        m_wlast   = '0;
        m_wvalid  = '0;
        m_bready  = '0;
        s_awready = '0;
        s_wready  = '0;
        s_bid     = '0;
        s_bresp   = '0;
        s_bvalid  = '0;
        {aw_fire, w_fire, w_last_fire, b_fire} = '0;
        cyc        = 0;
        done_count = 0;
        act_tx     = -1;
        read_trace();
        for (int m = 0; m < NUM_MASTERS; m++) begin
            mst_st[m]  = 0;
            mst_ptr[m] = find_next_tx(m, -1);
        end
        repeat (5) @(negedge ACLK);
        ARESETn = 1'b1;
        while (done_count < n_tr) begin
            @(negedge ACLK);
            cyc++;
            if (cyc > limit) begin
                $display("ERROR: run timed out after %0d cycles", cyc);
                $display("Simulation finished: FAIL");
                $fatal(1);
            end
            update_models();
            #1;
            sample_fires();
        end
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

// File: verilog.f
wr_arb_pkg.sv
wr_grant_fsm.sv
wr_master_mux.sv
wr_slave_route.sv
wr_arbiter_top.sv
wr_arbiter_assert.sv
tb_wr_arbiter.sv

// File: wr_arb_pkg.sv
package wr_arb_pkg;

    // ----------------------------------------------------------------------
    // fabric size
    // ----------------------------------------------------------------------
    localparam int NUM_MASTERS = 4;
    localparam int NUM_SLAVES  = 8;
    localparam int MIDX_W      = 2;                 // master index
    localparam int SIDX_W      = 3;                 // slave index, top address bits

    // ----------------------------------------------------------------------
    // AXI4 field widths
    // ----------------------------------------------------------------------
    localparam int DATA_W  = 32;
    localparam int STRB_W  = DATA_W / 8;
    localparam int ADDR_W  = 32;
    localparam int ID_W    = 4;
    localparam int LEN_W   = 8;
    localparam int SIZE_W  = 3;
    localparam int BURST_W = 2;
    localparam int RESP_W  = 2;

    // ----------------------------------------------------------------------
    // write address, seen either whole or split into slave and offset
    // ----------------------------------------------------------------------
    typedef struct packed {
        logic [SIDX_W-1:0]        sidx;             // selects one of eight slaves
        logic [ADDR_W-SIDX_W-1:0] offset;           // address inside the slave
    } aw_addr_fld_t;

    typedef union packed {
        logic [ADDR_W-1:0] raw;
        aw_addr_fld_t      fld;
    } aw_addr_u;

    // ----------------------------------------------------------------------
    // transaction phase of the current owner
    // ----------------------------------------------------------------------
    typedef enum logic [1:0] {
        PH_AW = 2'd0,                               // address handshake
        PH_W  = 2'd1,                               // data beats up to WLAST
        PH_B  = 2'd2                                // write response
    } wr_phase_e;

endpackage

// File: wr_arbiter_assert.sv
module wr_arbiter_assert (
    input  logic                                ACLK,
    input  logic                                ARESETn,
    input  logic [wr_arb_pkg::NUM_SLAVES-1:0]   s_awvalid,
    input  logic [wr_arb_pkg::NUM_SLAVES-1:0]   s_wvalid,
    input  logic [wr_arb_pkg::NUM_SLAVES-1:0]   s_wready,
    input  logic [wr_arb_pkg::NUM_MASTERS-1:0]  m_bvalid,
    input  wr_arb_pkg::wr_phase_e               phase,
    input  logic                                s_wlast
);

    timeunit 1ns;
    timeprecision 1ps;

    import wr_arb_pkg::*;

    // one slave sees the address at a time
    a_one_awvalid: assert property (@(posedge ACLK) disable iff (!ARESETn)
        $onehot0(s_awvalid)) else $error("more than one s_awvalid high");

    a_one_wvalid: assert property (@(posedge ACLK) disable iff (!ARESETn)
        $onehot0(s_wvalid)) else $error("more than one s_wvalid high");

    // response goes back to one master only
    a_one_bvalid: assert property (@(posedge ACLK) disable iff (!ARESETn)
        $onehot0(m_bvalid)) else $error("more than one m_bvalid high");

    // last beat as seen on the slave ports
    a_w_hold: assert property (@(posedge ACLK) disable iff (!ARESETn)
        (phase == PH_W) && !(|(s_wvalid & s_wready) && s_wlast) |=> (phase == PH_W))
        else $error("phase left PH_W without a WLAST transfer");

endmodule

bind wr_arbiter_top wr_arbiter_assert u_assert (.*);

// File: wr_arbiter_top.sv
module wr_arbiter_top (
    input  logic                                                        ACLK,
    input  logic                                                        ARESETn,
    // masters
    input  logic [wr_arb_pkg::NUM_MASTERS-1:0][wr_arb_pkg::ID_W-1:0]    m_awid,
    input  logic [wr_arb_pkg::NUM_MASTERS-1:0][wr_arb_pkg::ADDR_W-1:0]  m_awaddr,
    input  logic [wr_arb_pkg::NUM_MASTERS-1:0][wr_arb_pkg::LEN_W-1:0]   m_awlen,
    input  logic [wr_arb_pkg::NUM_MASTERS-1:0][wr_arb_pkg::SIZE_W-1:0]  m_awsize,
    input  logic [wr_arb_pkg::NUM_MASTERS-1:0][wr_arb_pkg::BURST_W-1:0] m_awburst,
    input  logic [wr_arb_pkg::NUM_MASTERS-1:0]                          m_awvalid,
    output logic [wr_arb_pkg::NUM_MASTERS-1:0]                          m_awready,
    input  logic [wr_arb_pkg::NUM_MASTERS-1:0][wr_arb_pkg::DATA_W-1:0]  m_wdata,
    input  logic [wr_arb_pkg::NUM_MASTERS-1:0][wr_arb_pkg::STRB_W-1:0]  m_wstrb,
    input  logic [wr_arb_pkg::NUM_MASTERS-1:0]                          m_wlast,
    input  logic [wr_arb_pkg::NUM_MASTERS-1:0]                          m_wvalid,
    output logic [wr_arb_pkg::NUM_MASTERS-1:0]                          m_wready,
    output logic [wr_arb_pkg::NUM_MASTERS-1:0][wr_arb_pkg::ID_W-1:0]    m_bid,
    output logic [wr_arb_pkg::NUM_MASTERS-1:0][wr_arb_pkg::RESP_W-1:0]  m_bresp,
    output logic [wr_arb_pkg::NUM_MASTERS-1:0]                          m_bvalid,
    input  logic [wr_arb_pkg::NUM_MASTERS-1:0]                          m_bready,
    // slaves, handshakes
    output logic [wr_arb_pkg::NUM_SLAVES-1:0]                           s_awvalid,
    input  logic [wr_arb_pkg::NUM_SLAVES-1:0]                           s_awready,
    output logic [wr_arb_pkg::NUM_SLAVES-1:0]                           s_wvalid,
    input  logic [wr_arb_pkg::NUM_SLAVES-1:0]                           s_wready,
    input  logic [wr_arb_pkg::NUM_SLAVES-1:0][wr_arb_pkg::ID_W-1:0]     s_bid,
    input  logic [wr_arb_pkg::NUM_SLAVES-1:0][wr_arb_pkg::RESP_W-1:0]   s_bresp,
    input  logic [wr_arb_pkg::NUM_SLAVES-1:0]                           s_bvalid,
    output logic [wr_arb_pkg::NUM_SLAVES-1:0]                           s_bready,
    // slaves, shared payload
    output logic [wr_arb_pkg::ID_W-1:0]                                 s_awid,
    output logic [wr_arb_pkg::ADDR_W-1:0]                               s_awaddr,
    output logic [wr_arb_pkg::LEN_W-1:0]                                s_awlen,
    output logic [wr_arb_pkg::SIZE_W-1:0]                               s_awsize,
    output logic [wr_arb_pkg::BURST_W-1:0]                              s_awburst,
    output logic [wr_arb_pkg::DATA_W-1:0]                               s_wdata,
    output logic [wr_arb_pkg::STRB_W-1:0]                               s_wstrb,
    output logic                                                        s_wlast
);

    import wr_arb_pkg::*;

    // ----------------------------------------------------------------------
    // internal wiring
    // ----------------------------------------------------------------------
    logic [MIDX_W-1:0] owner;
    wr_phase_e         phase;
    logic              sel_awvalid;
    logic              sel_wvalid;
    logic              sel_bready;
    logic              rt_awready;
    logic              rt_wready;
    logic              rt_bvalid;
    logic [ID_W-1:0]   rt_bid;
    logic [RESP_W-1:0] rt_bresp;

    // grant and phase
    wr_grant_fsm u_grant_fsm (
        .sel_wlast   (s_wlast),                     // shared WLAST is the owner's
        .*
    );

    // owner's fields go straight onto the shared slave payload
    wr_master_mux u_master_mux (
        .sel_awid    (s_awid),
        .sel_awaddr  (s_awaddr),
        .sel_awlen   (s_awlen),
        .sel_awsize  (s_awsize),
        .sel_awburst (s_awburst),
        .sel_wdata   (s_wdata),
        .sel_wstrb   (s_wstrb),
        .sel_wlast   (s_wlast),
        .*
    );

    // address decode and per-slave fan-out
    wr_slave_route u_slave_route (
        .sel_awaddr  (s_awaddr),
        .*
    );

endmodule

// File: wr_grant_fsm.sv
module wr_grant_fsm (
    input  logic                                ACLK,
    input  logic                                ARESETn,
    input  logic [wr_arb_pkg::NUM_MASTERS-1:0]  m_awvalid,
    input  logic                                sel_awvalid,
    input  logic                                rt_awready,
    input  logic                                sel_wvalid,
    input  logic                                rt_wready,
    input  logic                                sel_wlast,
    input  logic                                rt_bvalid,
    input  logic                                sel_bready,
    output logic [wr_arb_pkg::MIDX_W-1:0]       owner,
    output wr_arb_pkg::wr_phase_e               phase
);

    import wr_arb_pkg::*;

    logic [MIDX_W-1:0] owner_d;
    wr_phase_e         phase_d;
    logic [MIDX_W-1:0] req_idx;                     // nearest requester after owner
    logic              req_hit;
    logic              aw_done;
    logic              w_done;
    logic              b_done;

    assign aw_done = sel_awvalid && rt_awready;
    assign w_done  = sel_wvalid && rt_wready && sel_wlast;
    assign b_done  = rt_bvalid && sel_bready;

    // ----------------------------------------------------------------------
    // rotating priority search
    // ----------------------------------------------------------------------
    // walk downward so the master closest after the owner is the last one
    // written, which gives it the highest priority
    always_comb begin
        logic [MIDX_W-1:0] cand;
        req_idx = owner;
        req_hit = 1'b0;
        for (int i = NUM_MASTERS - 1; i > 0; i--) begin
            cand = owner + MIDX_W'(i);              // wraps modulo 4
            if (m_awvalid[cand]) begin
                req_idx = cand;
                req_hit = 1'b1;
            end
        end
    end

    // ----------------------------------------------------------------------
    // phase and owner next state
    // ----------------------------------------------------------------------
    always_comb begin
        phase_d = phase;
        owner_d = owner;
        case (phase)
            PH_AW: begin
                if (sel_awvalid) begin              // owner requests, hold grant
                    if (aw_done)
                        phase_d = PH_W;
                end else if (req_hit) begin
                    owner_d = req_idx;              // hand over, still in AW
                end
            end
            PH_W: begin
                if (w_done)                         // last beat accepted
                    phase_d = PH_B;
            end
            PH_B: begin
                if (b_done) begin
                    phase_d = PH_AW;
                    owner_d = owner + 1'b1;         // next master gets first look
                end
            end
            default: begin
                phase_d = PH_AW;
            end
        endcase
    end

    always_ff @(posedge ACLK or negedge ARESETn) begin
        if (!ARESETn) begin
            phase <= PH_AW;
            owner <= '0;
        end else begin
            phase <= phase_d;
            owner <= owner_d;
        end
    end

endmodule

// File: wr_master_mux.sv
module wr_master_mux (
    input  logic [wr_arb_pkg::MIDX_W-1:0]                               owner,
    // per-master AW
    input  logic [wr_arb_pkg::NUM_MASTERS-1:0][wr_arb_pkg::ID_W-1:0]    m_awid,
    input  logic [wr_arb_pkg::NUM_MASTERS-1:0][wr_arb_pkg::ADDR_W-1:0]  m_awaddr,
    input  logic [wr_arb_pkg::NUM_MASTERS-1:0][wr_arb_pkg::LEN_W-1:0]   m_awlen,
    input  logic [wr_arb_pkg::NUM_MASTERS-1:0][wr_arb_pkg::SIZE_W-1:0]  m_awsize,
    input  logic [wr_arb_pkg::NUM_MASTERS-1:0][wr_arb_pkg::BURST_W-1:0] m_awburst,
    input  logic [wr_arb_pkg::NUM_MASTERS-1:0]                          m_awvalid,
    output logic [wr_arb_pkg::NUM_MASTERS-1:0]                          m_awready,
    // per-master W
    input  logic [wr_arb_pkg::NUM_MASTERS-1:0][wr_arb_pkg::DATA_W-1:0]  m_wdata,
    input  logic [wr_arb_pkg::NUM_MASTERS-1:0][wr_arb_pkg::STRB_W-1:0]  m_wstrb,
    input  logic [wr_arb_pkg::NUM_MASTERS-1:0]                          m_wlast,
    input  logic [wr_arb_pkg::NUM_MASTERS-1:0]                          m_wvalid,
    output logic [wr_arb_pkg::NUM_MASTERS-1:0]                          m_wready,
    // per-master B
    output logic [wr_arb_pkg::NUM_MASTERS-1:0][wr_arb_pkg::ID_W-1:0]    m_bid,
    output logic [wr_arb_pkg::NUM_MASTERS-1:0][wr_arb_pkg::RESP_W-1:0]  m_bresp,
    output logic [wr_arb_pkg::NUM_MASTERS-1:0]                          m_bvalid,
    input  logic [wr_arb_pkg::NUM_MASTERS-1:0]                          m_bready,
    // owner's channel toward the slaves
    output logic [wr_arb_pkg::ID_W-1:0]                                 sel_awid,
    output logic [wr_arb_pkg::ADDR_W-1:0]                               sel_awaddr,
    output logic [wr_arb_pkg::LEN_W-1:0]                                sel_awlen,
    output logic [wr_arb_pkg::SIZE_W-1:0]                               sel_awsize,
    output logic [wr_arb_pkg::BURST_W-1:0]                              sel_awburst,
    output logic                                                        sel_awvalid,
    output logic [wr_arb_pkg::DATA_W-1:0]                               sel_wdata,
    output logic [wr_arb_pkg::STRB_W-1:0]                               sel_wstrb,
    output logic                                                        sel_wlast,
    output logic                                                        sel_wvalid,
    output logic                                                        sel_bready,
    // routed slave's answer
    input  logic                                                        rt_awready,
    input  logic                                                        rt_wready,
    input  logic                                                        rt_bvalid,
    input  logic [wr_arb_pkg::ID_W-1:0]                                 rt_bid,
    input  logic [wr_arb_pkg::RESP_W-1:0]                               rt_bresp
);

    import wr_arb_pkg::*;

    // ----------------------------------------------------------------------
    // owner to slave side
    // ----------------------------------------------------------------------
    assign sel_awid    = m_awid[owner];
    assign sel_awaddr  = m_awaddr[owner];
    assign sel_awlen   = m_awlen[owner];
    assign sel_awsize  = m_awsize[owner];
    assign sel_awburst = m_awburst[owner];
    assign sel_awvalid = m_awvalid[owner];
    assign sel_wdata   = m_wdata[owner];
    assign sel_wstrb   = m_wstrb[owner];
    assign sel_wlast   = m_wlast[owner];
    assign sel_wvalid  = m_wvalid[owner];
    assign sel_bready  = m_bready[owner];

    // ----------------------------------------------------------------------
    // ready and response back to the owner, zero elsewhere
    // ----------------------------------------------------------------------
    always_comb begin
        logic own;
        for (int i = 0; i < NUM_MASTERS; i++) begin
            own          = (owner == MIDX_W'(i));
            m_awready[i] = own & rt_awready;
            m_wready[i]  = own & rt_wready;
            m_bvalid[i]  = own & rt_bvalid;
            m_bid[i]     = own ? rt_bid : '0;
            m_bresp[i]   = own ? rt_bresp : '0;     // non-owners see OKAY/0
        end
    end

endmodule

// File: wr_slave_route.sv
module wr_slave_route (
    input  logic                                                        ACLK,
    input  logic                                                        ARESETn,
    input  wr_arb_pkg::wr_phase_e                                       phase,
    // owner's handshake and address
    input  logic                                                        sel_awvalid,
    input  logic [wr_arb_pkg::ADDR_W-1:0]                               sel_awaddr,
    input  logic                                                        sel_wvalid,
    input  logic                                                        sel_bready,
    // per-slave handshakes
    output logic [wr_arb_pkg::NUM_SLAVES-1:0]                           s_awvalid,
    input  logic [wr_arb_pkg::NUM_SLAVES-1:0]                           s_awready,
    output logic [wr_arb_pkg::NUM_SLAVES-1:0]                           s_wvalid,
    input  logic [wr_arb_pkg::NUM_SLAVES-1:0]                           s_wready,
    input  logic [wr_arb_pkg::NUM_SLAVES-1:0][wr_arb_pkg::ID_W-1:0]     s_bid,
    input  logic [wr_arb_pkg::NUM_SLAVES-1:0][wr_arb_pkg::RESP_W-1:0]   s_bresp,
    input  logic [wr_arb_pkg::NUM_SLAVES-1:0]                           s_bvalid,
    output logic [wr_arb_pkg::NUM_SLAVES-1:0]                           s_bready,
    // chosen slave's answer
    output logic                                                        rt_awready,
    output logic                                                        rt_wready,
    output logic                                                        rt_bvalid,
    output logic [wr_arb_pkg::ID_W-1:0]                                 rt_bid,
    output logic [wr_arb_pkg::RESP_W-1:0]                               rt_bresp
);

    import wr_arb_pkg::*;

    aw_addr_u          aw_addr;
    logic [SIDX_W-1:0] sidx_q;                      // slave taken at the AW transfer
    logic [SIDX_W-1:0] sidx;
    logic              aw_ph;
    logic              w_ph;
    logic              b_ph;

    assign aw_ph = (phase == PH_AW);
    assign w_ph  = (phase == PH_W);
    assign b_ph  = (phase == PH_B);

    assign aw_addr.raw = sel_awaddr;

    // ----------------------------------------------------------------------
    // slave select
    // ----------------------------------------------------------------------
    // live from the address while AW is open, then frozen so W and B keep
    // following the slave that took the address
    assign sidx = aw_ph ? aw_addr.fld.sidx : sidx_q;

    always_ff @(posedge ACLK or negedge ARESETn) begin
        if (!ARESETn)
            sidx_q <= '0;
        else if (aw_ph && sel_awvalid && rt_awready)
            sidx_q <= aw_addr.fld.sidx;
    end

    // ----------------------------------------------------------------------
    // fan-out to one slave
    // ----------------------------------------------------------------------
    always_comb begin
        logic hit;
        for (int s = 0; s < NUM_SLAVES; s++) begin
            hit          = (sidx == SIDX_W'(s));
            s_awvalid[s] = hit & aw_ph & sel_awvalid;
            s_wvalid[s]  = hit & w_ph & sel_wvalid;
            s_bready[s]  = hit & b_ph & sel_bready;
        end
    end

    // ----------------------------------------------------------------------
    // return path
    // ----------------------------------------------------------------------
    assign rt_awready = aw_ph & s_awready[sidx];    // only while AW is open
    assign rt_wready  = w_ph & s_wready[sidx];
    assign rt_bvalid  = b_ph & s_bvalid[sidx];
    assign rt_bid     = s_bid[sidx];
    assign rt_bresp   = s_bresp[sidx];

endmodule

// File: wr_trace.txt
# master addr(hex) awlen start_cycle bresp stall expected_b_rank
# rank counts B transfers from zero; slave is the top three address bits
0 00000100 3 2 0 0 0
2 40000200 1 60 0 0 1
1 E0000010 0 120 1 0 2
0 20000000 2 200 0 0 5
1 60000040 1 200 2 0 6
2 80000080 3 200 0 0 3
3 A00000C0 0 200 3 0 4
0 C0000000 7 400 0 1 9
1 00001000 5 400 0 1 10
2 E0002000 7 400 2 1 7
3 40003000 6 400 0 1 8
3 20004000 15 700 0 1 11
0 60005000 0 700 3 1 12
1 80006000 1 1000 0 0 13
2 A0007000 2 1000 1 0 14
0 C0008000 1 1100 0 1 15
1 E0009000 3 1100 2 1 16
3 1FFFFFFC 0 1200 0 0 17
